// File: Makefile
TOP = permutationTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -qxF '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log

// File: all.f
+incdir+include
verilog/permDataPkg.sv
verilog/permCtrlPkg.sv
verilog/resetNormalizer.sv
verilog/topManager.sv
verilog/activityCounter.sv
verilog/originQueue.sv
verilog/permutationPipeline.sv
verilog/permutationTop.sv
test/permutationTb.sv

// File: include/permTbTable.svh
`ifndef PERM_TB_TABLE_SVH
`define PERM_TB_TABLE_SVH

typedef struct packed {
    logic [permDataPkg::WORD_WIDTH-1:0] word;
    logic startNewTop;
    logic [7:0] gap;                   // Idle cycles before the next entry
} tbEntryT;

// Scoreboard record, sum and count only meaningful for a bot
typedef struct packed {
    permDataPkg::originT origin;
    logic [permDataPkg::SUM_WIDTH-1:0] sum;
    logic [permDataPkg::COUNT_WIDTH-1:0] count;
} tbExpectT;

localparam int TB_ENTRIES = 22;

localparam tbEntryT TB_TABLE [TB_ENTRIES] = '{
    '{128'h0123_4567_89ab_cdef_0f0f_0f0f_f0f0_f0f0, 1'b0, 8'd2},   // Before any top
    '{128'h0000_00ff_0000_0f0f_1234_5678_0000_0001, 1'b1, 8'd1},
    '{128'h0, 1'b0, 8'd1},
    '{{128{1'b1}}, 1'b0, 8'd1},
    '{128'h1, 1'b0, 8'd0},
    '{128'h8000_0000_0000_0000_0000_0000_0000_0000, 1'b0, 8'd3},
    '{{128{1'b1}}, 1'b1, 8'd2},
    '{128'hffff_0000_ffff_0000_ffff_0000_ffff_0000, 1'b0, 8'd12},
    '{128'h0000_0001_0000_0000_0000_0000_0000_0000, 1'b1, 8'd0},   // Back-to-back tops
    '{128'h0f0f_0f0f_0000_0000_ffff_ffff_0000_0001, 1'b1, 8'd4},
    '{128'h1357_9bdf_2468_ace0, 1'b0, 8'd0},                       // Burst start
    '{128'hdead_beef_0000_0000_cafe_f00d_0000_0000, 1'b0, 8'd0},
    '{{128{1'b1}}, 1'b0, 8'd0},
    '{128'h1, 1'b0, 8'd0},
    '{128'h5555_5555_5555_5555_5555_5555_5555_5555, 1'b0, 8'd0},
    '{128'haaaa_aaaa_0000_0000_aaaa_aaaa_0000_0000, 1'b0, 8'd0},
    '{128'h0000_ffff_0000_ffff_0000_ffff_0000_ffff, 1'b0, 8'd0},
    '{128'h8000_0000_8000_0000_8000_0000_8000_0000, 1'b0, 8'd0},
    '{128'h0, 1'b0, 8'd0},
    '{128'h7fff_ffff_0000_0000_0000_0000_ffff_fffe, 1'b0, 8'd0},
    '{128'h00ff_00ff_ff00_ff00_0000_0000_0000_0000, 1'b1, 8'd0},   // Top right after burst
    '{128'h0000_00ff_0000_00ff_0000_00ff_0000_00ff, 1'b0, 8'd0}
};

`endif

// File: test/permutationTb.sv
`timescale 1ns/1ps
`default_nettype none

module permutationTb;
    import permDataPkg::*;

    `include "permTbTable.svh"

    localparam int PIPE_DEPTH = 4;
    localparam int RESULT_DEPTH = 8;
    localparam int QUEUE_DEPTH_LOG2 = 4;
    localparam int WARMUP_CYCLES = 16;
    localparam int ROT_BITS = 32;           // Rotation step of the top
    localparam int READY_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 2000;

    logic clk;
    logic resetn;
    logic ivalid;
    logic startNewTop;
    logic [WORD_WIDTH/2-1:0] botLower;
    logic [WORD_WIDTH/2-1:0] botUpper;
    logic iready;
    logic oready;
    logic ovalid;
    logic [RESULT_WIDTH-1:0] result;

    tbExpectT scoreboard [$];               // One record per accepted word, in order
    logic [WORD_WIDTH-1:0] lastTop;
    logic [RESULT_WIDTH-1:0] heldResult;
    logic holdPending;
    int cycleNum;
    int lastTopXfer;                        // Cycle of the latest top record transfer
    int acceptedCount;
    int resultCount;
    int checkCount;
    int errorCount;
    int timeoutCount;

    permutationTop #(
        .PIPE_DEPTH(PIPE_DEPTH),
        .RESULT_DEPTH(RESULT_DEPTH),
        .QUEUE_DEPTH_LOG2(QUEUE_DEPTH_LOG2),
        .WARMUP_CYCLES(WARMUP_CYCLES)
    ) i_permutationTop (
        .clk(clk), .resetn(resetn), .ivalid(ivalid), .startNewTop(startNewTop),
        .botLower(botLower), .botUpper(botUpper), .iready(iready),
        .oready(oready), .ovalid(ovalid), .result(result)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleNum <= cycleNum + 1;
        iready <= ($urandom % 4) != 0;      // Low about a quarter of the time
    end

    function automatic tbExpectT referenceScore(input logic [WORD_WIDTH-1:0] botWord,
                                                input logic [WORD_WIDTH-1:0] topWord);
        tbExpectT expected;
        logic [WORD_WIDTH-1:0] rotated;
        int overlap;
        expected = '0;
        expected.origin = ORIGIN_BOT;
        for (int r = 0; r < 4; r++) begin
            overlap = 0;
            for (int i = 0; i < WORD_WIDTH; i++) begin
                rotated[i] = topWord[(i + ROT_BITS * r) % WORD_WIDTH];
                if (botWord[i] && rotated[i]) begin
                    overlap++;
                end
            end
            expected.sum += SUM_WIDTH'(overlap);
            if (overlap != 0) begin
                expected.count += 1'b1;
            end
        end
        return expected;
    endfunction

    task automatic reportError(input string msg);
        errorCount++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic finishRun();
        $display("Checks %0d, errors %0d, timeouts %0d, accepted %0d, results %0d",
            checkCount, errorCount, timeoutCount, acceptedCount, resultCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    task automatic abortOnTimeout(input string what);
        timeoutCount++;
        $display("Timeout while waiting for %s", what);
        finishRun();
    endtask

    task automatic compareResult(input tbExpectT expected);
        logic [CYCLE_WIDTH-1:0] cycles;
        logic [ACTIVITY_WIDTH-1:0] busy;
        cycles = result[CYCLE_LSB +: CYCLE_WIDTH];
        busy = result[ACTIVITY_LSB +: ACTIVITY_WIDTH];
        checkCount++;
        if (result[ORIGIN_BIT] != (expected.origin == ORIGIN_TOP)) begin
            reportError($sformatf("result %0d origin bit %0b, expected %s", resultCount,
                result[ORIGIN_BIT], (expected.origin == ORIGIN_TOP) ? "top" : "bot"));
        end else if (expected.origin == ORIGIN_TOP) begin
            if (cycles == 0) begin
                reportError($sformatf("top record %0d has zero cycle count", resultCount));
            end
            if (64'(busy) > 64'(PIPE_DEPTH) * 64'(cycles)) begin
                reportError($sformatf("top record %0d activity %0d over %0d cycles",
                    resultCount, busy, cycles));
            end
            // Back-to-back top records leave no time for a bot to occupy a stage
            if (lastTopXfer == cycleNum - 1 && busy != 0) begin
                reportError($sformatf("top record %0d right after a top shows activity %0d",
                    resultCount, busy));
            end
        end else begin
            if (result[SUM_LSB +: SUM_WIDTH] != expected.sum
                    || result[COUNT_LSB +: COUNT_WIDTH] != expected.count) begin
                reportError($sformatf("bot result %0d sum %0d count %0d, expected %0d %0d",
                    resultCount, result[SUM_LSB +: SUM_WIDTH],
                    result[COUNT_LSB +: COUNT_WIDTH], expected.sum, expected.count));
            end
        end
    endtask

    // Outputs are sampled mid-cycle, a transfer happens on the following rising edge
    task automatic observeOutput();
        tbExpectT expected;
        if (holdPending
                && (!ovalid || (!heldResult[ORIGIN_BIT] && result != heldResult))) begin
            reportError("ovalid or a bot result changed while iready was low");
        end
        holdPending = ovalid && !iready;
        heldResult = result;
        if (ovalid !== 1'b0 && scoreboard.size() == 0) begin
            reportError("ovalid high with no accepted word outstanding");
        end else if (ovalid && iready) begin
            expected = scoreboard.pop_front();
            compareResult(expected);
            if (expected.origin == ORIGIN_TOP) begin
                lastTopXfer = cycleNum;
            end
        end
        if (ovalid && iready) begin
            resultCount++;                  // Unexpected transfers count too
        end
    endtask

    always @(negedge clk) begin
        if (resetn) begin
            observeOutput();
        end
    end

    task automatic sendWord(input tbEntryT entry);
        int waited;
        ivalid <= 1'b1;
        startNewTop <= entry.startNewTop;
        botLower <= entry.word[WORD_WIDTH/2-1:0];
        botUpper <= entry.word[WORD_WIDTH-1:WORD_WIDTH/2];
        waited = 0;
        @(negedge clk);
        while (!oready) begin
            if (waited == READY_TIMEOUT) begin
                abortOnTimeout($sformatf("oready on word %0d", acceptedCount));
            end
            waited++;
            @(negedge clk);
        end
        @(posedge clk);                     // Word transfers here
        if (entry.startNewTop) begin
            scoreboard.push_back(tbExpectT'{origin: ORIGIN_TOP, sum: '0, count: '0});
            lastTop = entry.word;
        end else begin
            scoreboard.push_back(referenceScore(entry.word, lastTop));
        end
        acceptedCount++;
        if (entry.gap != 0) begin
            ivalid <= 1'b0;
            repeat (entry.gap) @(posedge clk);
        end
    endtask

    initial begin
        int waited;
        clk = 1'b0;
        resetn = 1'b0;
        ivalid = 1'b0;
        startNewTop = 1'b0;
        botLower = '0;
        botUpper = '0;
        iready = 1'b0;
        lastTop = '0;                       // Bots before the first top see zeros
        heldResult = '0;
        holdPending = 1'b0;
        cycleNum = 0;
        lastTopXfer = -10;
        acceptedCount = 0;
        resultCount = 0;
        checkCount = 0;
        errorCount = 0;
        timeoutCount = 0;
        void'($urandom(32'h1c26));
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        repeat (3) @(posedge clk);
        for (int i = 0; i < TB_ENTRIES; i++) begin
            sendWord(TB_TABLE[i]);
        end
        ivalid <= 1'b0;
        waited = 0;
        while (resultCount < acceptedCount) begin
            if (waited == DRAIN_TIMEOUT) begin
                abortOnTimeout("the final results to drain");
            end
            waited++;
            @(posedge clk);
        end
        repeat (20) @(posedge clk);         // Room for a stray duplicate to show up
        checkCount++;
        if (resultCount != acceptedCount) begin
            reportError($sformatf("%0d words accepted, %0d results",
                acceptedCount, resultCount));
        end
        finishRun();
    end

endmodule

`default_nettype wire

// File: verilog/activityCounter.sv
`timescale 1ns/1ps
`default_nettype none

module activityCounter #(
    parameter int PIPE_DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic clear,
    input  logic [$clog2(PIPE_DEPTH+1)-1:0] activity,
    output logic [permDataPkg::ACTIVITY_WIDTH-1:0] activityCount,
    output logic [permDataPkg::CYCLE_WIDTH-1:0] cycleCount
);
    import permDataPkg::*;

    logic [ACTIVITY_WIDTH:0] activitySum;  // One extra bit flags overflow

    assign activitySum = {1'b0, activityCount} + (ACTIVITY_WIDTH + 1)'(activity);

    always_ff @(posedge clk) begin
        if (rst) begin
            activityCount <= '0;
            cycleCount <= '0;
        end else if (clear) begin
            // The clearing cycle opens the next interval
            activityCount <= ACTIVITY_WIDTH'(activity);
            cycleCount <= CYCLE_WIDTH'(1);
        end else begin
            activityCount <= activitySum[ACTIVITY_WIDTH] ? '1 : activitySum[ACTIVITY_WIDTH-1:0];
            if (!(&cycleCount)) begin
                cycleCount <= cycleCount + 1'b1;   // Saturate
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/originQueue.sv
`timescale 1ns/1ps
`default_nettype none

module originQueue #(
    parameter int QUEUE_DEPTH_LOG2 = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  permDataPkg::originT pushOrigin,
    input  logic pop,
    output permDataPkg::originT headOrigin,
    output logic queueEmpty
);
    import permDataPkg::*;

    localparam int DEPTH = 2 ** QUEUE_DEPTH_LOG2;

    originT entries [DEPTH];
    logic [QUEUE_DEPTH_LOG2:0] wrPtr;      // Top bit tells wrap parity
    logic [QUEUE_DEPTH_LOG2:0] rdPtr;
    logic queueFull;

    assign queueEmpty = (wrPtr == rdPtr);
    assign queueFull = (wrPtr[QUEUE_DEPTH_LOG2] != rdPtr[QUEUE_DEPTH_LOG2])
        && (wrPtr[QUEUE_DEPTH_LOG2-1:0] == rdPtr[QUEUE_DEPTH_LOG2-1:0]);
    assign headOrigin = entries[rdPtr[QUEUE_DEPTH_LOG2-1:0]];   // Shown before the pop

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr[QUEUE_DEPTH_LOG2-1:0]] <= pushOrigin;
        end
    end

    noPushWhenFull: assert property (@(posedge clk) disable iff (rst)
        push |-> !queueFull);
    noPopWhenEmpty: assert property (@(posedge clk) disable iff (rst)
        pop |-> !queueEmpty);

endmodule

`default_nettype wire

// File: verilog/permCtrlPkg.sv
`default_nettype none

package permCtrlPkg;

    // Reset normalization
    typedef enum logic [1:0] {
        RST_HOLD   = 2'd0,             // Internal reset asserted
        RST_WARMUP = 2'd1,
        RST_DONE   = 2'd2
    } resetStateT;

    // Top register management
    typedef enum logic [1:0] {
        TOP_ACTIVE = 2'd0,
        TOP_DRAIN  = 2'd1,             // Waiting for the scoring stages to empty
        TOP_LOAD   = 2'd2
    } topStateT;

endpackage

`default_nettype wire

// File: verilog/permDataPkg.sv
`default_nettype none

package permDataPkg;

    localparam int WORD_WIDTH = 128;       // One bot or top word
    localparam int RESULT_WIDTH = 64;
    localparam int SUM_WIDTH = 48;
    localparam int COUNT_WIDTH = 13;
    localparam int ACTIVITY_WIDTH = 30;
    localparam int CYCLE_WIDTH = 31;

    // Bot score layout
    localparam int SUM_LSB = 0;
    localparam int COUNT_LSB = SUM_LSB + SUM_WIDTH;

    // Top record layout, bits 62:61 stay zero
    localparam int CYCLE_LSB = 0;
    localparam int ACTIVITY_LSB = CYCLE_LSB + CYCLE_WIDTH;
    localparam int ORIGIN_BIT = RESULT_WIDTH - 1;

    typedef enum logic {
        ORIGIN_BOT = 1'b0,
        ORIGIN_TOP = 1'b1              // Matches result bit 63
    } originT;

endpackage

`default_nettype wire

// File: verilog/permutationPipeline.sv
`timescale 1ns/1ps
`default_nettype none

module permutationPipeline #(
    parameter int PIPE_DEPTH = 4,      // At least 3
    parameter int RESULT_DEPTH = 8
) (
    input  logic clk,
    input  logic rst,
    input  logic writeBot,
    input  logic [permDataPkg::WORD_WIDTH-1:0] bot,
    input  logic [permDataPkg::WORD_WIDTH-1:0] currentTop,
    input  logic resultPop,
    output logic readyForBot,
    output logic resultValid,
    output logic [permDataPkg::SUM_WIDTH-1:0] sumOut,
    output logic [permDataPkg::COUNT_WIDTH-1:0] countOut,
    output logic [$clog2(PIPE_DEPTH+1)-1:0] activity,
    output logic pipelineEmpty
);
    import permDataPkg::*;

    localparam int ROTATIONS = 4;
    localparam int ROT_STEP = WORD_WIDTH / ROTATIONS;
    localparam int POP_WIDTH = $clog2(WORD_WIDTH + 1);
    localparam int STAGES = PIPE_DEPTH - 1;    // Registered stages ahead of the buffer
    localparam int ACT_WIDTH = $clog2(PIPE_DEPTH + 1);
    localparam int PTR_WIDTH = (RESULT_DEPTH > 1) ? $clog2(RESULT_DEPTH) : 1;
    localparam int FILL_WIDTH = $clog2(RESULT_DEPTH + 1);

    function automatic logic [POP_WIDTH-1:0] popCount(input logic [WORD_WIDTH-1:0] v);
        logic [POP_WIDTH-1:0] n;
        n = '0;
        for (int i = 0; i < WORD_WIDTH; i++) begin
            n += POP_WIDTH'(v[i]);
        end
        return n;
    endfunction

    function automatic logic [PTR_WIDTH-1:0] nextPtr(input logic [PTR_WIDTH-1:0] p);
        return (p == PTR_WIDTH'(RESULT_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    logic [STAGES-1:0] stageValid;
    logic [WORD_WIDTH-1:0] masked [ROTATIONS];
    logic [POP_WIDTH-1:0] popStage [STAGES-1][ROTATIONS];
    logic [SUM_WIDTH-1:0] finalSum;
    logic [COUNT_WIDTH-1:0] finalCount;
    logic bufWrite;
    logic [SUM_WIDTH-1:0] sumMem [RESULT_DEPTH];
    logic [COUNT_WIDTH-1:0] countMem [RESULT_DEPTH];
    logic [PTR_WIDTH-1:0] wrPtr;
    logic [PTR_WIDTH-1:0] rdPtr;
    logic [FILL_WIDTH-1:0] fill;
    logic [FILL_WIDTH-1:0] credits;        // Bots in flight plus buffered results

    always_ff @(posedge clk) begin
        if (rst) begin
            stageValid <= '0;
        end else begin
            stageValid <= {stageValid[STAGES-2:0], writeBot};
        end
    end

    always_ff @(posedge clk) begin
        for (int r = 0; r < ROTATIONS; r++) begin
            masked[r] <= bot & ((currentTop << (r * ROT_STEP))
                | (currentTop >> (WORD_WIDTH - r * ROT_STEP)));
            popStage[0][r] <= popCount(masked[r]);
            for (int s = 1; s < STAGES - 1; s++) begin
                popStage[s][r] <= popStage[s-1][r];   // Delay to the fixed depth
            end
        end
    end

    // Last stage adds the counts on the way into the buffer
    always_comb begin
        finalSum = '0;
        finalCount = '0;
        for (int r = 0; r < ROTATIONS; r++) begin
            finalSum += SUM_WIDTH'(popStage[STAGES-2][r]);
            finalCount += COUNT_WIDTH'(popStage[STAGES-2][r] != '0);
        end
    end

    assign bufWrite = stageValid[STAGES-1];

    always_ff @(posedge clk) begin
        if (bufWrite) begin
            sumMem[wrPtr] <= finalSum;
            countMem[wrPtr] <= finalCount;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fill <= '0;
            credits <= '0;
        end else begin
            if (bufWrite) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (resultPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            fill <= fill + FILL_WIDTH'(bufWrite) - FILL_WIDTH'(resultPop);
            credits <= credits + FILL_WIDTH'(writeBot) - FILL_WIDTH'(resultPop);
        end
    end

    assign readyForBot = (credits < FILL_WIDTH'(RESULT_DEPTH));
    assign resultValid = (fill != '0);
    assign sumOut = sumMem[rdPtr];
    assign countOut = countMem[rdPtr];
    assign activity = ACT_WIDTH'($countones(stageValid));
    assign pipelineEmpty = ~|stageValid;

    // Credits reserved at writeBot keep the buffer from overflowing later
    bufferNeverOverflows: assert property (@(posedge clk) disable iff (rst)
        bufWrite |-> (fill < FILL_WIDTH'(RESULT_DEPTH)) || resultPop);

endmodule

`default_nettype wire

// File: verilog/permutationTop.sv
`timescale 1ns/1ps
`default_nettype none

module permutationTop #(
    parameter int PIPE_DEPTH = 4,
    parameter int RESULT_DEPTH = 8,
    parameter int QUEUE_DEPTH_LOG2 = 4,
    parameter int WARMUP_CYCLES = 16
) (
    input  logic clk,
    input  logic resetn,
    input  logic ivalid,
    input  logic startNewTop,          // Word is a new top, not a bot
    input  logic [permDataPkg::WORD_WIDTH/2-1:0] botLower,
    input  logic [permDataPkg::WORD_WIDTH/2-1:0] botUpper,
    input  logic iready,
    output logic oready,
    output logic ovalid,
    output logic [permDataPkg::RESULT_WIDTH-1:0] result
);
    import permDataPkg::*;

    logic [WORD_WIDTH-1:0] ingressWord;
    logic botValid;
    logic topValid;
    logic rst;
    logic isInitialized;
    logic writeBot;
    logic writeTop;
    logic stallInput;
    logic [WORD_WIDTH-1:0] currentTop;
    originT pushOrigin;
    originT headOrigin;
    logic queueEmpty;
    logic outXfer;
    logic [ACTIVITY_WIDTH-1:0] activityCount;
    logic [CYCLE_WIDTH-1:0] cycleCount;
    logic readyForBot;
    logic resultValid;
    logic pipelineEmpty;
    logic [SUM_WIDTH-1:0] sumOut;
    logic [COUNT_WIDTH-1:0] countOut;
    logic [$clog2(PIPE_DEPTH+1)-1:0] activity;

    // One-deep ingress queue, lets oready rise long before warm-up ends
    always_ff @(posedge clk) begin
        if (oready) begin
            ingressWord <= {botUpper, botLower};
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            botValid <= 1'b0;
            topValid <= 1'b0;
        end else if (oready) begin
            botValid <= ivalid && !startNewTop;
            topValid <= ivalid && startNewTop;
        end
    end

    assign oready = (readyForBot && !stallInput && isInitialized)
        || (!botValid && !topValid && !rst);
    assign writeBot = botValid && oready;
    assign writeTop = topValid && oready;
    assign pushOrigin = writeTop ? ORIGIN_TOP : ORIGIN_BOT;

    assign ovalid = !queueEmpty && (headOrigin == ORIGIN_TOP || resultValid);
    assign outXfer = ovalid && iready;

    always_comb begin
        result = '0;
        result[ORIGIN_BIT] = (headOrigin == ORIGIN_TOP);
        if (headOrigin == ORIGIN_TOP) begin
            result[ACTIVITY_LSB +: ACTIVITY_WIDTH] = activityCount;
            result[CYCLE_LSB +: CYCLE_WIDTH] = cycleCount;
        end else begin
            result[COUNT_LSB +: COUNT_WIDTH] = countOut;
            result[SUM_LSB +: SUM_WIDTH] = sumOut;
        end
    end

    resetNormalizer #(.WARMUP_CYCLES(WARMUP_CYCLES)) i_resetNormalizer (
        .clk(clk), .resetn(resetn), .rst(rst), .isInitialized(isInitialized)
    );

    topManager i_topManager (
        .clk(clk), .rst(rst), .topIn(ingressWord), .writeTop(writeTop),
        .pipelineEmpty(pipelineEmpty), .stallInput(stallInput), .currentTop(currentTop)
    );

    originQueue #(.QUEUE_DEPTH_LOG2(QUEUE_DEPTH_LOG2)) i_originQueue (
        .clk(clk), .rst(rst), .push(writeTop || writeBot), .pushOrigin(pushOrigin),
        .pop(outXfer), .headOrigin(headOrigin), .queueEmpty(queueEmpty)
    );

    activityCounter #(.PIPE_DEPTH(PIPE_DEPTH)) i_activityCounter (
        .clk(clk), .rst(rst), .clear(outXfer && headOrigin == ORIGIN_TOP),
        .activity(activity), .activityCount(activityCount), .cycleCount(cycleCount)
    );

    permutationPipeline #(
        .PIPE_DEPTH(PIPE_DEPTH),
        .RESULT_DEPTH(RESULT_DEPTH)
    ) i_permutationPipeline (
        .clk(clk), .rst(rst), .writeBot(writeBot), .bot(ingressWord),
        .currentTop(currentTop), .resultPop(outXfer && headOrigin == ORIGIN_BOT),
        .readyForBot(readyForBot), .resultValid(resultValid), .sumOut(sumOut),
        .countOut(countOut), .activity(activity), .pipelineEmpty(pipelineEmpty)
    );

endmodule

`default_nettype wire

// File: verilog/resetNormalizer.sv
`timescale 1ns/1ps
`default_nettype none

module resetNormalizer #(
    parameter int WARMUP_CYCLES = 16
) (
    input  logic clk,
    input  logic resetn,
    output logic rst,
    output logic isInitialized
);
    import permCtrlPkg::*;

    localparam int WARM_WIDTH = $clog2(WARMUP_CYCLES + 1);

    resetStateT state;
    logic resetnQ;                     // Delayed copy stretches rst by one cycle
    logic [WARM_WIDTH-1:0] warmCount;

    always_ff @(posedge clk) begin
        resetnQ <= resetn;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= RST_HOLD;
            warmCount <= '0;
        end else begin
            case (state)
                RST_HOLD: begin
                    if (resetnQ) begin
                        state <= RST_WARMUP;
                    end
                end
                RST_WARMUP: begin
                    warmCount <= warmCount + 1'b1;
                    if (warmCount == WARM_WIDTH'(WARMUP_CYCLES - 1)) begin
                        state <= RST_DONE;
                    end
                end
                default: state <= RST_DONE;
            endcase
        end
    end

    assign rst = (state == RST_HOLD);
    assign isInitialized = (state == RST_DONE);

    // Warm-up must run its full length with rst already released
    initDoneAfterWarmup: assert property (@(posedge clk) disable iff (!resetn)
        $rose(isInitialized) |-> !rst && $past(!rst, WARMUP_CYCLES));

endmodule

`default_nettype wire

// File: verilog/topManager.sv
`timescale 1ns/1ps
`default_nettype none

module topManager (
    input  logic clk,
    input  logic rst,
    input  logic [permDataPkg::WORD_WIDTH-1:0] topIn,
    input  logic writeTop,
    input  logic pipelineEmpty,
    output logic stallInput,
    output logic [permDataPkg::WORD_WIDTH-1:0] currentTop
);
    import permDataPkg::*;
    import permCtrlPkg::*;

    topStateT state;
    logic [WORD_WIDTH-1:0] pendingTop;     // New top waiting for the drain

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= TOP_ACTIVE;
            currentTop <= '0;                  // Early bots score against zero
        end else begin
            case (state)
                TOP_ACTIVE: begin
                    if (writeTop) begin
                        state <= TOP_DRAIN;
                    end
                end
                TOP_DRAIN: begin
                    if (pipelineEmpty) begin
                        state <= TOP_LOAD;
                    end
                end
                TOP_LOAD: begin
                    currentTop <= pendingTop;
                    state <= TOP_ACTIVE;
                end
                default: state <= TOP_ACTIVE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == TOP_ACTIVE && writeTop) begin
            pendingTop <= topIn;
        end
    end

    assign stallInput = (state != TOP_ACTIVE);

    // Bots in flight never see the top change under them
    topChangesOnLoad: assert property (@(posedge clk) disable iff (rst)
        !$stable(currentTop) |-> $past(state) == TOP_LOAD);

endmodule

`default_nettype wire
